/* hdl/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Datapath word width
`define EXEC_DATA_W 32

// Register file address width
`define EXEC_REG_W 5

// Width of the Tnew count carried down the pipe
`define EXEC_TNEW_W 2

// Busy cycles after a multiply is issued
`define EXEC_MULT_CYCLES 5

// Busy cycles after a divide is issued
`define EXEC_DIV_CYCLES 10

`endif

/* hdl/execPkg.sv */
`default_nettype none

`include "exec_consts.svh"

package execPkg;

    // Instructions seen by the execute stage
    typedef enum logic [5:0] {
        OP_NOP, OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLTI, OP_SLTIU, OP_LUI,
        OP_LW, OP_SW,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_JAL
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ZERO, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } aluOpT;

    // Coarse grouping used for result selection
    typedef enum logic [2:0] {
        IC_CALC_R, IC_CALC_I, IC_MEM_READ, IC_MEM_WRITE, IC_MULDIV, IC_OTHER
    } instrClassT;

    // Decoded instruction from the ID/EX register
    typedef struct packed {
        opcodeT                     opcode;
        logic [`EXEC_DATA_W-1:0]    pc;
        logic [`EXEC_DATA_W-1:0]    dataRs;
        logic [`EXEC_DATA_W-1:0]    dataRt;
        logic [15:0]                imm16;
        logic [4:0]                 shamt;
        logic [`EXEC_REG_W-1:0]     addrRs;
        logic [`EXEC_REG_W-1:0]     addrRt;
        logic [`EXEC_REG_W-1:0]     regWriteAddr;
        logic [`EXEC_DATA_W-1:0]    regWriteData;
        logic [`EXEC_TNEW_W-1:0]    tnew;
    } exInputT;

    // Write-back value of a later stage
    typedef struct packed {
        logic [`EXEC_REG_W-1:0]     regAddr;
        logic [`EXEC_DATA_W-1:0]    regData;
    } fwdPortT;

    // Contents of the EX/MEM register
    typedef struct packed {
        opcodeT                     opcode;
        logic [`EXEC_DATA_W-1:0]    pc;
        logic [`EXEC_DATA_W-1:0]    result;
        logic [`EXEC_DATA_W-1:0]    memWriteData;
        logic [`EXEC_REG_W-1:0]     addrRt;
        logic [`EXEC_REG_W-1:0]     regWriteAddr;
        logic [`EXEC_DATA_W-1:0]    regWriteData;
        logic [`EXEC_TNEW_W-1:0]    tnew;
    } exOutputT;

endpackage

`default_nettype wire

/* hdl/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  execPkg::opcodeT     opcode,
    output execPkg::instrClassT instrClass,
    output execPkg::aluOpT      aluOp,
    output logic                signExtend,
    output logic                useImm,
    output logic                useShamt
);

    always_comb begin
        case (opcode)
            execPkg::OP_ADD, execPkg::OP_ADDU, execPkg::OP_SUB, execPkg::OP_SUBU,
            execPkg::OP_AND, execPkg::OP_OR, execPkg::OP_XOR, execPkg::OP_NOR,
            execPkg::OP_SLT, execPkg::OP_SLTU,
            execPkg::OP_SLL, execPkg::OP_SRL, execPkg::OP_SRA,
            execPkg::OP_SLLV, execPkg::OP_SRLV, execPkg::OP_SRAV:
                instrClass = execPkg::IC_CALC_R;
            execPkg::OP_ADDI, execPkg::OP_ADDIU, execPkg::OP_ANDI, execPkg::OP_ORI,
            execPkg::OP_XORI, execPkg::OP_SLTI, execPkg::OP_SLTIU, execPkg::OP_LUI:
                instrClass = execPkg::IC_CALC_I;
            execPkg::OP_LW:
                instrClass = execPkg::IC_MEM_READ;
            execPkg::OP_SW:
                instrClass = execPkg::IC_MEM_WRITE;
            execPkg::OP_MULT, execPkg::OP_MULTU, execPkg::OP_DIV, execPkg::OP_DIVU,
            execPkg::OP_MFHI, execPkg::OP_MFLO, execPkg::OP_MTHI, execPkg::OP_MTLO:
                instrClass = execPkg::IC_MULDIV;
            default:
                instrClass = execPkg::IC_OTHER;
        endcase
    end

    // Loads and stores compute their address with an add
    always_comb begin
        case (opcode)
            execPkg::OP_ADD, execPkg::OP_ADDU, execPkg::OP_ADDI, execPkg::OP_ADDIU,
            execPkg::OP_LW, execPkg::OP_SW:
                aluOp = execPkg::ALU_ADD;
            execPkg::OP_SUB, execPkg::OP_SUBU:    aluOp = execPkg::ALU_SUB;
            execPkg::OP_AND, execPkg::OP_ANDI:    aluOp = execPkg::ALU_AND;
            execPkg::OP_OR, execPkg::OP_ORI:      aluOp = execPkg::ALU_OR;
            execPkg::OP_XOR, execPkg::OP_XORI:    aluOp = execPkg::ALU_XOR;
            execPkg::OP_NOR:                      aluOp = execPkg::ALU_NOR;
            execPkg::OP_SLT, execPkg::OP_SLTI:    aluOp = execPkg::ALU_SLT;
            execPkg::OP_SLTU, execPkg::OP_SLTIU:  aluOp = execPkg::ALU_SLTU;
            execPkg::OP_SLL, execPkg::OP_SLLV:    aluOp = execPkg::ALU_SLL;
            execPkg::OP_SRL, execPkg::OP_SRLV:    aluOp = execPkg::ALU_SRL;
            execPkg::OP_SRA, execPkg::OP_SRAV:    aluOp = execPkg::ALU_SRA;
            execPkg::OP_LUI:                      aluOp = execPkg::ALU_LUI;
            default:                              aluOp = execPkg::ALU_ZERO;
        endcase
    end

    // Logical immediates are zero extended
    assign signExtend = !(opcode == execPkg::OP_ANDI || opcode == execPkg::OP_ORI ||
                          opcode == execPkg::OP_XORI || opcode == execPkg::OP_LUI);

    assign useImm = (instrClass == execPkg::IC_CALC_I) ||
                    (instrClass == execPkg::IC_MEM_READ) ||
                    (instrClass == execPkg::IC_MEM_WRITE);

    // Only the fixed shifts take the amount from shamt
    assign useShamt = (opcode == execPkg::OP_SLL) || (opcode == execPkg::OP_SRL) ||
                      (opcode == execPkg::OP_SRA);

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module alu (
    input  execPkg::aluOpT              aluOp,
    input  logic                        signExtend,
    input  logic                        useImm,
    input  logic                        useShamt,
    input  logic [`EXEC_DATA_W-1:0]     rsVal,
    input  logic [`EXEC_DATA_W-1:0]     rtVal,
    input  logic [15:0]                 imm16,
    input  logic [4:0]                  shamt,
    output logic [`EXEC_DATA_W-1:0]     aluOut
);

    logic [`EXEC_DATA_W-1:0] extImm;
    logic [`EXEC_DATA_W-1:0] opA;
    logic [`EXEC_DATA_W-1:0] opB;

    assign extImm = signExtend ? {{(`EXEC_DATA_W-16){imm16[15]}}, imm16}
                               : {{(`EXEC_DATA_W-16){1'b0}}, imm16};

    // Fixed shifts take their amount from shamt, variable shifts from rs
    assign opA = useShamt ? {{(`EXEC_DATA_W-5){1'b0}}, shamt} : rsVal;
    assign opB = useImm ? extImm : rtVal;

    always_comb begin
        case (aluOp)
            execPkg::ALU_ADD:  aluOut = opA + opB;
            execPkg::ALU_SUB:  aluOut = opA - opB;
            execPkg::ALU_AND:  aluOut = opA & opB;
            execPkg::ALU_OR:   aluOut = opA | opB;
            execPkg::ALU_XOR:  aluOut = opA ^ opB;
            execPkg::ALU_NOR:  aluOut = ~(opA | opB);
            execPkg::ALU_SLT:
                aluOut = {{(`EXEC_DATA_W-1){1'b0}}, ($signed(opA) < $signed(opB))};
            execPkg::ALU_SLTU:
                aluOut = {{(`EXEC_DATA_W-1){1'b0}}, (opA < opB)};
            // Shifts move b by a
            execPkg::ALU_SLL:  aluOut = opB << opA[4:0];
            execPkg::ALU_SRL:  aluOut = opB >> opA[4:0];
            execPkg::ALU_SRA:  aluOut = $signed(opB) >>> opA[4:0];
            execPkg::ALU_LUI:  aluOut = {opB[15:0], 16'b0};
            default:           aluOut = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/multDiv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module multDiv (
    input  logic                        clk,
    input  logic                        reset,
    input  execPkg::opcodeT             opcode,
    input  logic [`EXEC_DATA_W-1:0]     rsVal,
    input  logic [`EXEC_DATA_W-1:0]     rtVal,
    output logic                        busy,
    output logic [`EXEC_DATA_W-1:0]     mdOut
);

    logic [`EXEC_DATA_W-1:0]            hi;
    logic [`EXEC_DATA_W-1:0]            lo;
    logic [3:0]                         count;
    logic                               isMult;
    logic                               isDiv;
    logic                               isUnsigned;
    logic                               issue;
    logic signed [2*`EXEC_DATA_W-1:0]   extRs;
    logic signed [2*`EXEC_DATA_W-1:0]   extRt;
    logic signed [2*`EXEC_DATA_W-1:0]   product;
    logic signed [2*`EXEC_DATA_W-1:0]   quotient;
    logic signed [2*`EXEC_DATA_W-1:0]   remainder;

    assign isMult = (opcode == execPkg::OP_MULT) || (opcode == execPkg::OP_MULTU);
    assign isDiv = (opcode == execPkg::OP_DIV) || (opcode == execPkg::OP_DIVU);
    assign isUnsigned = (opcode == execPkg::OP_MULTU) || (opcode == execPkg::OP_DIVU);

    // New operations are only accepted once the countdown is idle
    assign issue = (count == 4'd0) && (isMult || isDiv);
    assign busy = (count != 4'd0) || issue;

    // Zero extension keeps unsigned operands positive in the signed math
    assign extRs = isUnsigned ? {{`EXEC_DATA_W{1'b0}}, rsVal}
                              : {{`EXEC_DATA_W{rsVal[`EXEC_DATA_W-1]}}, rsVal};
    assign extRt = isUnsigned ? {{`EXEC_DATA_W{1'b0}}, rtVal}
                              : {{`EXEC_DATA_W{rtVal[`EXEC_DATA_W-1]}}, rtVal};

    assign product = extRs * extRt;
    assign quotient = extRs / extRt;
    assign remainder = extRs % extRt;

    // HI/LO reads return zero while an operation is in flight
    always_comb begin
        mdOut = '0;
        if (!busy) begin
            if (opcode == execPkg::OP_MFHI) begin
                mdOut = hi;
            end else if (opcode == execPkg::OP_MFLO) begin
                mdOut = lo;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
            count <= 4'd0;
        end else if (count != 4'd0) begin
            count <= count - 4'd1;
        end else if (isMult) begin
            hi <= product[2*`EXEC_DATA_W-1:`EXEC_DATA_W];
            lo <= product[`EXEC_DATA_W-1:0];
            count <= 4'(`EXEC_MULT_CYCLES);
        end else if (isDiv) begin
            // Remainder to HI, quotient to LO
            hi <= remainder[`EXEC_DATA_W-1:0];
            lo <= quotient[`EXEC_DATA_W-1:0];
            count <= 4'(`EXEC_DIV_CYCLES);
        end else if (opcode == execPkg::OP_MTHI) begin
            hi <= rsVal;
        end else if (opcode == execPkg::OP_MTLO) begin
            lo <= rsVal;
        end
    end

endmodule

`default_nettype wire

/* hdl/forwardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module forwardUnit (
    input  logic [`EXEC_REG_W-1:0]      addrRs,
    input  logic [`EXEC_REG_W-1:0]      addrRt,
    input  logic [`EXEC_DATA_W-1:0]     dataRs,
    input  logic [`EXEC_DATA_W-1:0]     dataRt,
    input  execPkg::fwdPortT            fwdMem,
    input  execPkg::fwdPortT            fwdWb,
    output logic [`EXEC_DATA_W-1:0]     rsVal,
    output logic [`EXEC_DATA_W-1:0]     rtVal
);

    // MEM is younger than WB, so it is checked first; $zero never forwards
    function automatic logic [`EXEC_DATA_W-1:0] resolve(
        input logic [`EXEC_REG_W-1:0]  addr,
        input logic [`EXEC_DATA_W-1:0] regVal,
        input execPkg::fwdPortT        mem,
        input execPkg::fwdPortT        wb
    );
        logic [`EXEC_DATA_W-1:0] value;
        value = regVal;
        if (mem.regAddr == addr && mem.regAddr != '0) begin
            value = mem.regData;
        end else if (wb.regAddr == addr && wb.regAddr != '0) begin
            value = wb.regData;
        end
        return value;
    endfunction

    assign rsVal = resolve(addrRs, dataRs, fwdMem, fwdWb);
    assign rtVal = resolve(addrRt, dataRt, fwdMem, fwdWb);

endmodule

`default_nettype wire

/* hdl/execStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module execStage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                clr,
    input  execPkg::exInputT    exIn,
    input  execPkg::fwdPortT    fwdMem,
    input  execPkg::fwdPortT    fwdWb,
    output execPkg::exOutputT   exOut,
    output logic                mdBusy
);

    logic [`EXEC_DATA_W-1:0]    rsVal;
    logic [`EXEC_DATA_W-1:0]    rtVal;
    logic [`EXEC_DATA_W-1:0]    aluOut;
    logic [`EXEC_DATA_W-1:0]    mdOut;
    logic [`EXEC_DATA_W-1:0]    result;
    logic [`EXEC_DATA_W-1:0]    regWriteData;
    logic [`EXEC_TNEW_W-1:0]    tnewNext;
    execPkg::instrClassT        instrClass;
    execPkg::aluOpT             aluOp;
    logic                       signExtend;
    logic                       useImm;
    logic                       useShamt;
    logic                       isMoveFrom;
    execPkg::exOutputT          exNext;

    forwardUnit fwd (
        .addrRs (exIn.addrRs),
        .addrRt (exIn.addrRt),
        .dataRs (exIn.dataRs),
        .dataRt (exIn.dataRt),
        .fwdMem (fwdMem),
        .fwdWb  (fwdWb),
        .rsVal  (rsVal),
        .rtVal  (rtVal)
    );

    instrDecode dec (
        .opcode     (exIn.opcode),
        .instrClass (instrClass),
        .aluOp      (aluOp),
        .signExtend (signExtend),
        .useImm     (useImm),
        .useShamt   (useShamt)
    );

    alu aluUnit (
        .aluOp      (aluOp),
        .signExtend (signExtend),
        .useImm     (useImm),
        .useShamt   (useShamt),
        .rsVal      (rsVal),
        .rtVal      (rtVal),
        .imm16      (exIn.imm16),
        .shamt      (exIn.shamt),
        .aluOut     (aluOut)
    );

    multDiv md (
        .clk    (clk),
        .reset  (reset),
        .opcode (exIn.opcode),
        .rsVal  (rsVal),
        .rtVal  (rtVal),
        .busy   (mdBusy),
        .mdOut  (mdOut)
    );

    assign isMoveFrom = (exIn.opcode == execPkg::OP_MFHI) ||
                        (exIn.opcode == execPkg::OP_MFLO);
    assign result = isMoveFrom ? mdOut : aluOut;

    // Non-ALU instructions keep the value decode already chose
    always_comb begin
        if (isMoveFrom) begin
            regWriteData = mdOut;
        end else if (instrClass == execPkg::IC_CALC_R || instrClass == execPkg::IC_CALC_I) begin
            regWriteData = aluOut;
        end else begin
            regWriteData = exIn.regWriteData;
        end
    end

    // One stage closer to ready, never below zero
    assign tnewNext = (exIn.tnew != '0) ? exIn.tnew - 1'b1 : '0;

    always_comb begin
        exNext.opcode = exIn.opcode;
        exNext.pc = exIn.pc;
        exNext.result = result;
        exNext.memWriteData = rtVal;
        exNext.addrRt = exIn.addrRt;
        exNext.regWriteAddr = exIn.regWriteAddr;
        exNext.regWriteData = regWriteData;
        exNext.tnew = tnewNext;
    end

    // EX/MEM register, clear wins over stall
    always_ff @(posedge clk) begin
        if (reset || clr) begin
            exOut <= '0;
        end else if (!stall) begin
            exOut <= exNext;
        end
    end

endmodule

`default_nettype wire

/* test/execStage_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module execStageChk (
    input logic                 clk,
    input logic                 reset,
    input logic                 stall,
    input logic                 clr,
    input execPkg::exInputT     exIn,
    input execPkg::exOutputT    exOut,
    input logic                 mdBusy
);

    logic [3:0] remaining;
    logic       isMulDiv;
    logic       isMult;
    logic       isMoveFrom;
    int         failCount = 0;

    assign isMult = (exIn.opcode == execPkg::OP_MULT) || (exIn.opcode == execPkg::OP_MULTU);
    assign isMulDiv = isMult || (exIn.opcode == execPkg::OP_DIV) ||
                      (exIn.opcode == execPkg::OP_DIVU);
    assign isMoveFrom = (exIn.opcode == execPkg::OP_MFHI) || (exIn.opcode == execPkg::OP_MFLO);

    // Cycles of busy still owed after an issue
    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= 4'd0;
        end else if (remaining != 4'd0) begin
            remaining <= remaining - 4'd1;
        end else if (isMulDiv) begin
            remaining <= isMult ? 4'(`EXEC_MULT_CYCLES) : 4'(`EXEC_DIV_CYCLES);
        end
    end

    clearToZero: assert property (@(posedge clk) (reset || clr) |=> (exOut == '0))
        else begin
            $error("exOut not zero after reset or clr");
            failCount++;
        end

    stallHolds: assert property (@(posedge clk) (!reset && !clr && stall) |=> $stable(exOut))
        else begin
            $error("exOut changed during a stall");
            failCount++;
        end

    busyWindow: assert property (@(posedge clk) disable iff (reset) (remaining != 4'd0) |-> mdBusy)
        else begin
            $error("mdBusy fell before the multiply or divide finished");
            failCount++;
        end

    busyEnds: assert property (@(posedge clk) disable iff (reset)
            (remaining == 4'd0 && !isMulDiv) |-> !mdBusy)
        else begin
            $error("mdBusy stayed high past the busy interval");
            failCount++;
        end

    // HI/LO reads are blanked while busy
    moveFromZero: assert property (@(posedge clk) disable iff (reset)
            (mdBusy && isMoveFrom && !stall && !clr) |=> (exOut.result == '0))
        else begin
            $error("MFHI or MFLO returned data while busy");
            failCount++;
        end

endmodule

`default_nettype wire

/* test/execStageTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_consts.svh"

module execStageTb;

    logic               clk;
    logic               reset;
    logic               stall;
    logic               clr;
    execPkg::exInputT   exIn;
    execPkg::fwdPortT   fwdMem;
    execPkg::fwdPortT   fwdWb;
    execPkg::exOutputT  exOut;
    logic               mdBusy;
    logic [31:0]        hiModel;
    logic [31:0]        loModel;
    integer             seed;
    int                 errors;
    int                 testErrors;
    int                 checks;
    int                 tests;

    execStage uut (
        .clk(clk), .reset(reset), .stall(stall), .clr(clr), .exIn(exIn),
        .fwdMem(fwdMem), .fwdWb(fwdWb), .exOut(exOut), .mdBusy(mdBusy)
    );

    bind execStage execStageChk chk (
        .clk(clk), .reset(reset), .stall(stall), .clr(clr), .exIn(exIn),
        .exOut(exOut), .mdBusy(mdBusy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // MEM first, then WB, register zero never
    function automatic logic [31:0] operand(input logic [4:0] addr, input logic [31:0] regVal);
        if (addr != 5'd0 && fwdMem.regAddr == addr) return fwdMem.regData;
        if (addr != 5'd0 && fwdWb.regAddr == addr) return fwdWb.regData;
        return regVal;
    endfunction

    function automatic logic [31:0] aluModel(input execPkg::opcodeT op, input logic [31:0] rs,
            input logic [31:0] rt, input logic [15:0] imm, input logic [4:0] sh);
        logic [31:0] sext;
        logic [31:0] zext;
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        case (op)
            execPkg::OP_ADD, execPkg::OP_ADDU: return rs + rt;
            execPkg::OP_SUB, execPkg::OP_SUBU: return rs - rt;
            execPkg::OP_AND: return rs & rt;
            execPkg::OP_OR: return rs | rt;
            execPkg::OP_XOR: return rs ^ rt;
            execPkg::OP_NOR: return ~(rs | rt);
            execPkg::OP_SLT: return {31'b0, $signed(rs) < $signed(rt)};
            execPkg::OP_SLTU: return {31'b0, rs < rt};
            execPkg::OP_SLL: return rt << sh;
            execPkg::OP_SRL: return rt >> sh;
            execPkg::OP_SRA: return $signed(rt) >>> sh;
            execPkg::OP_SLLV: return rt << rs[4:0];
            execPkg::OP_SRLV: return rt >> rs[4:0];
            execPkg::OP_SRAV: return $signed(rt) >>> rs[4:0];
            execPkg::OP_ADDI, execPkg::OP_ADDIU, execPkg::OP_LW, execPkg::OP_SW: return rs + sext;
            execPkg::OP_ANDI: return rs & zext;
            execPkg::OP_ORI: return rs | zext;
            execPkg::OP_XORI: return rs ^ zext;
            execPkg::OP_SLTI: return {31'b0, $signed(rs) < $signed(sext)};
            execPkg::OP_SLTIU: return {31'b0, rs < sext};
            execPkg::OP_LUI: return {imm, 16'h0000};
            default: return 32'h0;
        endcase
    endfunction

    function automatic execPkg::exInputT randomInstr(input execPkg::opcodeT op);
        execPkg::exInputT instr;
        instr.opcode = op;
        instr.pc = $random(seed);
        instr.dataRs = $random(seed);
        instr.dataRt = $random(seed);
        instr.imm16 = 16'($random(seed));
        instr.shamt = 5'($random(seed));
        instr.addrRs = 5'($random(seed));
        instr.addrRt = 5'($random(seed));
        instr.regWriteAddr = 5'($random(seed));
        instr.regWriteData = $random(seed);
        instr.tnew = 2'($random(seed));
        return instr;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checks++;
        assert (expected == actual) else begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            errors++;
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        tests++;
        $display("test %s done, %0d errors", name, testErrors);
        testErrors = 0;
    endtask

    // Apply one instruction and let the EX/MEM register take it
    task automatic step(input execPkg::exInputT instr);
        exIn = instr;
        @(posedge clk);
        #1;
    endtask

    task automatic execute(input string name, input execPkg::exInputT instr);
        logic [31:0] rsv;
        logic [31:0] rtv;
        logic [31:0] aluVal;
        logic [31:0] mdVal;
        logic [31:0] res;
        logic [31:0] rwd;
        logic [1:0] tnewExp;
        logic isMoveFrom;
        logic isCalc;
        rsv = operand(instr.addrRs, instr.dataRs);
        rtv = operand(instr.addrRt, instr.dataRt);
        aluVal = aluModel(instr.opcode, rsv, rtv, instr.imm16, instr.shamt);
        mdVal = (instr.opcode == execPkg::OP_MFHI) ? hiModel : loModel;
        isMoveFrom = (instr.opcode == execPkg::OP_MFHI) || (instr.opcode == execPkg::OP_MFLO);
        isCalc = (instr.opcode >= execPkg::OP_ADD) && (instr.opcode <= execPkg::OP_LUI);
        res = isMoveFrom ? mdVal : aluVal;
        rwd = isMoveFrom ? mdVal : (isCalc ? aluVal : instr.regWriteData);
        tnewExp = (instr.tnew == 2'd0) ? 2'd0 : instr.tnew - 2'd1;
        if (instr.opcode == execPkg::OP_MTHI) hiModel = rsv;
        if (instr.opcode == execPkg::OP_MTLO) loModel = rsv;
        step(instr);
        compare({name, " opcode"}, 32'(instr.opcode), 32'(exOut.opcode));
        compare({name, " pc"}, instr.pc, exOut.pc);
        compare({name, " result"}, res, exOut.result);
        compare({name, " regWriteData"}, rwd, exOut.regWriteData);
        compare({name, " memWriteData"}, rtv, exOut.memWriteData);
        compare({name, " addrRt"}, 32'(instr.addrRt), 32'(exOut.addrRt));
        compare({name, " regWriteAddr"}, 32'(instr.regWriteAddr), 32'(exOut.regWriteAddr));
        compare({name, " tnew"}, 32'(tnewExp), 32'(exOut.tnew));
    endtask

    task automatic waitIdle(input string name);
        int cycles;
        cycles = 0;
        exIn = '0;
        while (mdBusy && cycles < `EXEC_DIV_CYCLES + 4) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (mdBusy) begin
            $display("%s timed out waiting for mdBusy to fall", name);
            errors++;
            testErrors++;
        end
    endtask

    task automatic mulDivCase(input execPkg::opcodeT op);
        execPkg::exInputT instr;
        longint a;
        longint b;
        string name;
        name = op.name();
        instr = randomInstr(op);
        if (instr.dataRt == 32'h0) instr.dataRt = 32'h1;
        if (op == execPkg::OP_MULTU || op == execPkg::OP_DIVU) begin
            a = {32'h0, instr.dataRs};
            b = {32'h0, instr.dataRt};
        end else begin
            a = $signed(instr.dataRs);
            b = $signed(instr.dataRt);
        end
        if (op == execPkg::OP_MULT || op == execPkg::OP_MULTU) begin
            {hiModel, loModel} = a * b;
        end else begin
            hiModel = 32'(a % b);
            loModel = 32'(a / b);
        end
        step(instr);
        // Early read lands in the busy window
        instr.opcode = execPkg::OP_MFHI;
        step(instr);
        waitIdle(name);
        execute({name, " hi"}, randomInstr(execPkg::OP_MFHI));
        execute({name, " lo"}, randomInstr(execPkg::OP_MFLO));
    endtask

    initial begin
        execPkg::exInputT instr;
        execPkg::opcodeT op;
        logic [31:0] held;
        seed = 32'h2f74;
        errors = 0;
        testErrors = 0;
        checks = 0;
        tests = 0;
        hiModel = 32'h0;
        loModel = 32'h0;
        reset = 1'b1;
        stall = 1'b0;
        clr = 1'b0;
        exIn = '0;
        fwdMem = '0;
        fwdWb = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        compare("reset exOut", 32'h0, {31'b0, |exOut});
        compare("reset mdBusy", 32'h0, {31'b0, mdBusy});
        finishTest("reset");

        for (int i = int'(execPkg::OP_ADD); i <= int'(execPkg::OP_LUI); i++) begin
            op = execPkg::opcodeT'(i);
            repeat (8) execute(op.name(), randomInstr(op));
        end
        finishTest("alu");

        instr = randomInstr(execPkg::OP_SW);
        instr.addrRs = 5'd5;
        instr.addrRt = 5'd5;
        instr.imm16 = 16'h0;
        fwdMem = {5'd5, 32'h1111_0000};
        fwdWb = {5'd5, 32'h2222_0000};
        execute("fwd mem", instr);
        fwdMem.regAddr = 5'd7;
        execute("fwd wb", instr);
        instr.addrRs = 5'd0;
        instr.addrRt = 5'd0;
        fwdMem.regAddr = 5'd0;
        fwdWb.regAddr = 5'd0;
        execute("fwd zero", instr);
        fwdMem = '0;
        fwdWb = '0;
        finishTest("forwarding");

        for (int i = int'(execPkg::OP_MULT); i <= int'(execPkg::OP_DIVU); i++) begin
            repeat (3) mulDivCase(execPkg::opcodeT'(i));
        end
        execute("mthi", randomInstr(execPkg::OP_MTHI));
        execute("mtlo", randomInstr(execPkg::OP_MTLO));
        execute("mthi read", randomInstr(execPkg::OP_MFHI));
        execute("mtlo read", randomInstr(execPkg::OP_MFLO));
        finishTest("multdiv");

        instr = randomInstr(execPkg::OP_ADD);
        execute("stall load", instr);
        held = aluModel(instr.opcode, instr.dataRs, instr.dataRt, instr.imm16, instr.shamt);
        stall = 1'b1;
        step(randomInstr(execPkg::OP_SUB));
        compare("stall hold", held, exOut.result);
        clr = 1'b1;
        step(randomInstr(execPkg::OP_OR));
        compare("clear under stall", 32'h0, {31'b0, |exOut});
        stall = 1'b0;
        clr = 1'b0;
        finishTest("stall clear");

        for (int i = 0; i < 4; i++) begin
            execute("lw", randomInstr(execPkg::OP_LW));
            execute("sw", randomInstr(execPkg::OP_SW));
            execute("jal", randomInstr(execPkg::OP_JAL));
        end
        finishTest("pass-through");

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, uut.chk.failCount);
        if (errors == 0 && uut.chk.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/execPkg.sv
hdl/instrDecode.sv
hdl/alu.sv
hdl/multDiv.sv
hdl/forwardUnit.sv
hdl/execStage.sv
test/execStage_chk.sv
test/execStageTb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module execStageTb -o execStageSim \
    && ./obj_dir/execStageSim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
# The run passes only if the testbench printed its pass line
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
